// File: adder_pkg.sv
package adder_pkg;

    // Slave port geometry
    localparam int ADDR_WIDTH = 8;
    localparam int DATA_WIDTH = 32;
    localparam int STRB_WIDTH = DATA_WIDTH / 8;

    // Register map, byte offsets
    localparam logic [7:0] REG_OPERAND_A = 8'h00;
    localparam logic [7:0] REG_OPERAND_B = 8'h04;
    localparam logic [7:0] REG_SUM       = 8'h08;
    localparam logic [7:0] REG_STATUS    = 8'h0C;

    typedef enum logic [1:0]
    {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axi_resp_t;

    // Write path: idle, or holding a response for the master
    typedef enum logic
    {
        WR_IDLE = 1'b0,
        WR_RESP = 1'b1
    } wr_state_t;

    // Read path: idle, or holding read data
    typedef enum logic
    {
        RD_IDLE = 1'b0,
        RD_DATA = 1'b1
    } rd_state_t;

endpackage

// File: axil_write_channel.sv
`timescale 1ns/10ps

module axil_write_channel
    import adder_pkg::*;
(
    input  logic                  s0_axi_aclk,
    input  logic                  rst,

    input  logic [ADDR_WIDTH-1:0] awaddr,
    input  logic                  awvalid,
    output logic                  awready,

    input  logic [DATA_WIDTH-1:0] wdata,
    input  logic [STRB_WIDTH-1:0] wstrb,
    input  logic                  wvalid,
    output logic                  wready,

    output axi_resp_t             bresp,
    output logic                  bvalid,
    input  logic                  bready,

    output logic                  wr_en,
    output logic [ADDR_WIDTH-1:0] wr_addr,
    output logic [DATA_WIDTH-1:0] wr_data,
    output logic [STRB_WIDTH-1:0] wr_strb,
    input  logic                  wr_err
);

    wr_state_t wr_state;
    logic      accept;

    // AW and W are taken together, as a single beat
    assign accept = awready && awvalid && wvalid;

    always_ff @(posedge s0_axi_aclk)
    begin
        if (rst)
        begin
            wr_state <= WR_IDLE;
            awready  <= 1'b0;
            bresp    <= RESP_OKAY;
        end
        else
        begin
            case (wr_state)
                WR_IDLE:
                begin
                    if (accept)
                    begin
                        awready  <= 1'b0;
                        bresp    <= wr_err ? RESP_SLVERR : RESP_OKAY;
                        wr_state <= WR_RESP;
                    end
                    else if (awvalid && wvalid)
                    begin
                        awready <= 1'b1;
                    end
                end
                WR_RESP:
                begin
                    // Hold until the master takes the response
                    if (bready)
                    begin
                        wr_state <= WR_IDLE;
                    end
                end
                default:
                begin
                    wr_state <= WR_IDLE;
                end
            endcase
        end
    end

    assign wready = awready;
    assign bvalid = (wr_state == WR_RESP);

    assign wr_en   = accept;
    assign wr_addr = awaddr;
    assign wr_data = wdata;
    assign wr_strb = wstrb;

    a_bvalid_hold: assert property (@(posedge s0_axi_aclk) disable iff (rst)
        bvalid && !bready |=> bvalid);

    a_no_accept_during_resp: assert property (@(posedge s0_axi_aclk) disable iff (rst)
        bvalid |-> !(awready || wready));

endmodule

// File: axil_read_channel.sv
`timescale 1ns/10ps

module axil_read_channel
    import adder_pkg::*;
(
    input  logic                  s0_axi_aclk,
    input  logic                  rst,

    input  logic [ADDR_WIDTH-1:0] araddr,
    input  logic                  arvalid,
    output logic                  arready,

    output logic [DATA_WIDTH-1:0] rdata,
    output axi_resp_t             rresp,
    output logic                  rvalid,
    input  logic                  rready,

    output logic [ADDR_WIDTH-1:0] rd_addr,
    input  logic [DATA_WIDTH-1:0] rd_data,
    input  logic                  rd_err
);

    rd_state_t rd_state;

    always_ff @(posedge s0_axi_aclk)
    begin
        if (rst)
        begin
            rd_state <= RD_IDLE;
            arready  <= 1'b0;
        end
        else if (rd_state == RD_IDLE)
        begin
            if (arready && arvalid)
            begin
                arready  <= 1'b0;
                rd_state <= RD_DATA;
            end
            else if (arvalid)
            begin
                arready <= 1'b1;
            end
        end
        else if (rready)
        begin
            rd_state <= RD_IDLE;
        end
    end

    // Capture on the address handshake only
    always_ff @(posedge s0_axi_aclk)
    begin
        if (rd_state == RD_IDLE && arready && arvalid)
        begin
            rdata <= rd_data;
            rresp <= rd_err ? RESP_SLVERR : RESP_OKAY;
        end
    end

    assign rvalid  = (rd_state == RD_DATA);
    assign rd_addr = araddr;

    a_rdata_stable: assert property (@(posedge s0_axi_aclk) disable iff (rst)
        rvalid && !rready |=> $stable(rdata));

endmodule

// File: adder_regs.sv
`timescale 1ns/10ps

module adder_regs
    import adder_pkg::*;
(
    input  logic                  s0_axi_aclk,
    input  logic                  rst,

    input  logic                  wr_en,
    input  logic [ADDR_WIDTH-1:0] wr_addr,
    input  logic [DATA_WIDTH-1:0] wr_data,
    input  logic [STRB_WIDTH-1:0] wr_strb,
    output logic                  wr_err,

    input  logic [ADDR_WIDTH-1:0] rd_addr,
    output logic [DATA_WIDTH-1:0] rd_data,
    output logic                  rd_err
);

    logic [DATA_WIDTH-1:0] operand_a;
    logic [DATA_WIDTH-1:0] operand_b;
    logic [DATA_WIDTH-1:0] sum;
    logic                  carry;
    logic [ADDR_WIDTH-1:0] wr_word;
    logic [ADDR_WIDTH-1:0] rd_word;

    // Low two address bits select a byte lane, not a register
    assign wr_word = {wr_addr[ADDR_WIDTH-1:2], 2'b00};
    assign rd_word = {rd_addr[ADDR_WIDTH-1:2], 2'b00};

    // Only the operands are writable
    assign wr_err = !(wr_word == REG_OPERAND_A || wr_word == REG_OPERAND_B);

    always_ff @(posedge s0_axi_aclk)
    begin
        if (rst)
        begin
            operand_a <= '0;
            operand_b <= '0;
        end
        else if (wr_en && !wr_err)
        begin
            for (int i = 0; i < STRB_WIDTH; i++)
            begin
                if (wr_strb[i] && wr_word == REG_OPERAND_A)
                    operand_a[i*8 +: 8] <= wr_data[i*8 +: 8];
                if (wr_strb[i] && wr_word == REG_OPERAND_B)
                    operand_b[i*8 +: 8] <= wr_data[i*8 +: 8];
            end
        end
    end

    // Sum lags the operands by one cycle
    always_ff @(posedge s0_axi_aclk)
    begin
        if (rst)
            {carry, sum} <= '0;
        else
            {carry, sum} <= {1'b0, operand_a} + {1'b0, operand_b};
    end

    always_comb
    begin
        rd_err = 1'b0;
        case (rd_word)
            REG_OPERAND_A: rd_data = operand_a;
            REG_OPERAND_B: rd_data = operand_b;
            REG_SUM:       rd_data = sum;
            REG_STATUS:    rd_data = {{(DATA_WIDTH-1){1'b0}}, carry};
            default:
            begin
                rd_data = '0;
                rd_err  = 1'b1;
            end
        endcase
    end

    a_err_write_ignored: assert property (@(posedge s0_axi_aclk) disable iff (rst)
        wr_en && wr_err |=> $stable(operand_a) && $stable(operand_b));

endmodule

// File: adder.sv
`timescale 1ns/10ps

module adder
    import adder_pkg::*;
(
    input  logic                  s0_axi_aclk,
    input  logic                  rst,

    input  logic [ADDR_WIDTH-1:0] s0_axi_awaddr,
    input  logic                  s0_axi_awvalid,
    output logic                  s0_axi_awready,

    input  logic [DATA_WIDTH-1:0] s0_axi_wdata,
    input  logic [STRB_WIDTH-1:0] s0_axi_wstrb,
    input  logic                  s0_axi_wvalid,
    output logic                  s0_axi_wready,

    output axi_resp_t             s0_axi_bresp,
    output logic                  s0_axi_bvalid,
    input  logic                  s0_axi_bready,

    input  logic [ADDR_WIDTH-1:0] s0_axi_araddr,
    input  logic                  s0_axi_arvalid,
    output logic                  s0_axi_arready,

    output logic [DATA_WIDTH-1:0] s0_axi_rdata,
    output axi_resp_t             s0_axi_rresp,
    output logic                  s0_axi_rvalid,
    input  logic                  s0_axi_rready
);

    logic                  wr_en;
    logic [ADDR_WIDTH-1:0] wr_addr;
    logic [DATA_WIDTH-1:0] wr_data;
    logic [STRB_WIDTH-1:0] wr_strb;
    logic                  wr_err;
    logic [ADDR_WIDTH-1:0] rd_addr;
    logic [DATA_WIDTH-1:0] rd_data;
    logic                  rd_err;

    axil_write_channel u_write_channel (
        .s0_axi_aclk (s0_axi_aclk),
        .rst         (rst),
        .awaddr      (s0_axi_awaddr),
        .awvalid     (s0_axi_awvalid),
        .awready     (s0_axi_awready),
        .wdata       (s0_axi_wdata),
        .wstrb       (s0_axi_wstrb),
        .wvalid      (s0_axi_wvalid),
        .wready      (s0_axi_wready),
        .bresp       (s0_axi_bresp),
        .bvalid      (s0_axi_bvalid),
        .bready      (s0_axi_bready),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .wr_strb     (wr_strb),
        .wr_err      (wr_err)
    );

    axil_read_channel u_read_channel (
        .s0_axi_aclk (s0_axi_aclk),
        .rst         (rst),
        .araddr      (s0_axi_araddr),
        .arvalid     (s0_axi_arvalid),
        .arready     (s0_axi_arready),
        .rdata       (s0_axi_rdata),
        .rresp       (s0_axi_rresp),
        .rvalid      (s0_axi_rvalid),
        .rready      (s0_axi_rready),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data),
        .rd_err      (rd_err)
    );

    adder_regs u_regs (
        .s0_axi_aclk (s0_axi_aclk),
        .rst         (rst),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .wr_strb     (wr_strb),
        .wr_err      (wr_err),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data),
        .rd_err      (rd_err)
    );

endmodule

// File: tb_adder.sv
`timescale 1ns/10ps

module tb_adder
    import adder_pkg::*;
();

    localparam int CYCLES_PER_LINE = 20;

    logic                  s0_axi_aclk;
    logic                  rst;
    logic [ADDR_WIDTH-1:0] s0_axi_awaddr;
    logic                  s0_axi_awvalid;
    logic                  s0_axi_awready;
    logic [DATA_WIDTH-1:0] s0_axi_wdata;
    logic [STRB_WIDTH-1:0] s0_axi_wstrb;
    logic                  s0_axi_wvalid;
    logic                  s0_axi_wready;
    axi_resp_t             s0_axi_bresp;
    logic                  s0_axi_bvalid;
    logic                  s0_axi_bready;
    logic [ADDR_WIDTH-1:0] s0_axi_araddr;
    logic                  s0_axi_arvalid;
    logic                  s0_axi_arready;
    logic [DATA_WIDTH-1:0] s0_axi_rdata;
    axi_resp_t             s0_axi_rresp;
    logic                  s0_axi_rvalid;
    logic                  s0_axi_rready;

    // One entry per golden line
    logic [7:0]            op_q[$];
    logic [ADDR_WIDTH-1:0] addr_q[$];
    logic [DATA_WIDTH-1:0] data_q[$];
    logic [STRB_WIDTH-1:0] strb_q[$];
    logic [1:0]            resp_q[$];
    logic [DATA_WIDTH-1:0] expected_q[$];

    int cycle_count;
    int cycle_limit;
    int error_count;
    int pass_count;
    int fail_count;

    adder DUT (
        .s0_axi_aclk    (s0_axi_aclk),
        .rst            (rst),
        .s0_axi_awaddr  (s0_axi_awaddr),
        .s0_axi_awvalid (s0_axi_awvalid),
        .s0_axi_awready (s0_axi_awready),
        .s0_axi_wdata   (s0_axi_wdata),
        .s0_axi_wstrb   (s0_axi_wstrb),
        .s0_axi_wvalid  (s0_axi_wvalid),
        .s0_axi_wready  (s0_axi_wready),
        .s0_axi_bresp   (s0_axi_bresp),
        .s0_axi_bvalid  (s0_axi_bvalid),
        .s0_axi_bready  (s0_axi_bready),
        .s0_axi_araddr  (s0_axi_araddr),
        .s0_axi_arvalid (s0_axi_arvalid),
        .s0_axi_arready (s0_axi_arready),
        .s0_axi_rdata   (s0_axi_rdata),
        .s0_axi_rresp   (s0_axi_rresp),
        .s0_axi_rvalid  (s0_axi_rvalid),
        .s0_axi_rready  (s0_axi_rready)
    );

    initial
    begin
        s0_axi_aclk = 1'b0;
        forever #5 s0_axi_aclk = ~s0_axi_aclk;
    end

    // Armed once the golden file is loaded
    initial
    begin
        cycle_count = 0;
        wait (cycle_limit > 0);
        while (cycle_count < cycle_limit)
        begin
            @(posedge s0_axi_aclk);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
        $display("SIMULATION FAILED");
        $finish;
    end

    task automatic check_value(
        input string       name,
        input logic [31:0] got,
        input logic [31:0] expected
    );
        if (got !== expected)
        begin
            $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, expected);
            error_count++;
        end
    endtask

    task automatic record_result(input string label, input int errors_before);
        if (error_count == errors_before)
        begin
            $display("%s: pass", label);
            pass_count++;
        end
        else
        begin
            $display("%s: fail", label);
            fail_count++;
        end
    endtask

    task automatic load_golden();
        int                    fd;
        int                    count;
        string                 line;
        logic [7:0]            op;
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] data;
        logic [STRB_WIDTH-1:0] strb;
        logic [1:0]            resp;
        logic [DATA_WIDTH-1:0] expected;
        fd = $fopen("adder_golden.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open adder_golden.txt for reading");
            error_count++;
            return;
        end
        while (!$feof(fd))
        begin
            line = "";
            void'($fgets(line, fd));
            // Skip blank lines and comments
            if (line.len() < 2 || line.getc(0) == "#")
                continue;
            count = $sscanf(line, "%c %h %h %h %h %h", op, addr, data, strb, resp, expected);
            if (count != 6 || (op != "W" && op != "R"))
            begin
                $display("Malformed line in golden file: %s", line);
                error_count++;
            end
            else
            begin
                op_q.push_back(op);
                addr_q.push_back(addr);
                data_q.push_back(data);
                strb_q.push_back(strb);
                resp_q.push_back(resp);
                expected_q.push_back(expected);
            end
        end
        $fclose(fd);
    endtask

    // Random stall before taking a response
    task automatic backpressure_delay();
        int unsigned wait_cycles;
        wait_cycles = $urandom % 4;
        repeat (wait_cycles)
        begin
            @(negedge s0_axi_aclk);
        end
    endtask

    task automatic write_transaction(
        input  logic [ADDR_WIDTH-1:0] addr,
        input  logic [DATA_WIDTH-1:0] data,
        input  logic [STRB_WIDTH-1:0] strb,
        output logic [1:0]            resp
    );
        @(negedge s0_axi_aclk);
        s0_axi_awaddr  = addr;
        s0_axi_wdata   = data;
        s0_axi_wstrb   = strb;
        s0_axi_awvalid = 1'b1;
        s0_axi_wvalid  = 1'b1;
        @(negedge s0_axi_aclk);
        while (!s0_axi_awready)
        begin
            @(negedge s0_axi_aclk);
        end
        check_value("wready", 32'(s0_axi_wready), 32'h1);
        // Handshake on the edge just passed
        @(negedge s0_axi_aclk);
        s0_axi_awvalid = 1'b0;
        s0_axi_wvalid  = 1'b0;
        backpressure_delay();
        while (!s0_axi_bvalid)
        begin
            @(negedge s0_axi_aclk);
        end
        s0_axi_bready = 1'b1;
        resp = s0_axi_bresp;
        @(negedge s0_axi_aclk);
        s0_axi_bready = 1'b0;
        check_value("bvalid after handshake", 32'(s0_axi_bvalid), 32'h0);
    endtask

    task automatic read_transaction(
        input  logic [ADDR_WIDTH-1:0] addr,
        output logic [DATA_WIDTH-1:0] data,
        output logic [1:0]            resp
    );
        @(negedge s0_axi_aclk);
        s0_axi_araddr  = addr;
        s0_axi_arvalid = 1'b1;
        @(negedge s0_axi_aclk);
        while (!s0_axi_arready)
        begin
            @(negedge s0_axi_aclk);
        end
        @(negedge s0_axi_aclk);
        s0_axi_arvalid = 1'b0;
        backpressure_delay();
        while (!s0_axi_rvalid)
        begin
            @(negedge s0_axi_aclk);
        end
        s0_axi_rready = 1'b1;
        data = s0_axi_rdata;
        resp = s0_axi_rresp;
        @(negedge s0_axi_aclk);
        s0_axi_rready = 1'b0;
        check_value("rvalid after handshake", 32'(s0_axi_rvalid), 32'h0);
    endtask

    initial
    begin
        logic [1:0]            resp;
        logic [DATA_WIDTH-1:0] rdata;
        int                    errors_before;
        string                 label;

        void'($urandom(84));
        rst            = 1'b1;
        s0_axi_awaddr  = '0;
        s0_axi_awvalid = 1'b0;
        s0_axi_wdata   = '0;
        s0_axi_wstrb   = '0;
        s0_axi_wvalid  = 1'b0;
        s0_axi_bready  = 1'b0;
        s0_axi_araddr  = '0;
        s0_axi_arvalid = 1'b0;
        s0_axi_rready  = 1'b0;
        error_count    = 0;
        pass_count     = 0;
        fail_count     = 0;

        load_golden();
        if (op_q.size() == 0)
        begin
            $display("The golden file holds no transactions");
            error_count++;
        end
        // Reset cycles plus a budget per transaction
        cycle_limit = CYCLES_PER_LINE * op_q.size() + 2;

        repeat (2)
        begin
            @(negedge s0_axi_aclk);
        end
        rst = 1'b0;

        errors_before = error_count;
        check_value("bvalid", 32'(s0_axi_bvalid), 32'h0);
        check_value("rvalid", 32'(s0_axi_rvalid), 32'h0);
        record_result("reset", errors_before);

        for (int i = 0; i < op_q.size(); i++)
        begin
            errors_before = error_count;
            if (op_q[i] == "W")
            begin
                write_transaction(addr_q[i], data_q[i], strb_q[i], resp);
                check_value("bresp", 32'(resp), 32'(resp_q[i]));
            end
            else
            begin
                read_transaction(addr_q[i], rdata, resp);
                check_value("rresp", 32'(resp), 32'(resp_q[i]));
                check_value("rdata", rdata, expected_q[i]);
            end
            label = $sformatf("line %0d %c 0x%02h", i, op_q[i], addr_q[i]);
            record_result(label, errors_before);
        end

        $display("Tests passed: %0d, failed: %0d, errors: %0d",
                 pass_count, fail_count, error_count);
        if (error_count == 0 && fail_count == 0)
        begin
            $display("SIMULATION PASSED");
        end
        else
        begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: adder_golden.txt
# op addr data strb resp rdata, all fields hex except op (W or R)
# resp is the expected bresp or rresp, rdata the expected read value (ignored for writes)
R 00 00000000 0 0 00000000
R 04 00000000 0 0 00000000
R 08 00000000 0 0 00000000
R 0C 00000000 0 0 00000000
W 00 12345678 F 0 00000000
W 04 11111111 F 0 00000000
R 00 00000000 0 0 12345678
R 04 00000000 0 0 11111111
R 08 00000000 0 0 23456789
R 0C 00000000 0 0 00000000
W 00 FFFFFFFF F 0 00000000
W 04 00000001 F 0 00000000
R 08 00000000 0 0 00000000
R 0C 00000000 0 0 00000001
W 00 AABBCCDD 5 0 00000000
R 00 00000000 0 0 FFBBFFDD
W 04 00002200 2 0 00000000
R 04 00000000 0 0 00002201
R 08 00000000 0 0 FFBC21DE
R 0C 00000000 0 0 00000000
W 08 DEADBEEF F 2 00000000
W 0C DEADBEEF F 2 00000000
W 10 DEADBEEF F 2 00000000
R 00 00000000 0 0 FFBBFFDD
R 04 00000000 0 0 00002201
R 0B 00000000 0 0 FFBC21DE
R 10 00000000 0 2 00000000
R 3C 00000000 0 2 00000000

// File: tb.f
adder_pkg.sv
axil_write_channel.sv
axil_read_channel.sv
adder_regs.sv
adder.sv
tb_adder.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds and runs the adder testbench with Verilator, result taken from sim.log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f tb.f --top-module tb_adder -o tb_adder_sim \
    && ./obj_dir/tb_adder_sim | tee sim.log

grep -qx "SIMULATION PASSED" sim.log && exit 0 || exit 1
